// ==== common/beam_fmt_pkg.sv ====
// beamformer numeric formats for samples and weights, with rounding and saturation constants
`default_nettype none

package beam_fmt_pkg;

    // beat shape
    localparam int num_channels = 4;
    localparam int num_lanes    = 8;

    // component widths, weights are Q0.7 fractions
    localparam int sample_w         = 16;
    localparam int weight_w         = 8;
    localparam int weight_frac_bits = 7;

    // a weight times a sample, and the sum of two such products
    localparam int product_w      = sample_w + weight_w;
    localparam int weighted_acc_w = product_w + 1;

    // four channels summed need two guard bits above a sample
    localparam int beam_sum_w    = sample_w + 2;
    localparam int combine_shift = 2;

    // half-up rounding adds half of the dropped LSB weight before the shift
    localparam int weight_round  = 1 << (weight_frac_bits - 1);
    localparam int combine_round = 1 << (combine_shift - 1);

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic signed [weight_w-1:0] weight_t;

    // saturation limits for one sample component
    localparam sample_t sample_max = {1'b0, {(sample_w - 1){1'b1}}};
    localparam sample_t sample_min = {1'b1, {(sample_w - 1){1'b0}}};

    // the most negative weight code cannot be represented below one in magnitude
    localparam weight_t weight_min = {1'b1, {(weight_w - 1){1'b0}}};

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    typedef struct packed {
        weight_t re;
        weight_t im;
    } cplx_weight_t;

endpackage

`default_nettype wire

// ==== common/beam_stream_pkg.sv ====
// beamformer stream beats for the input, weighted and combined data paths
`default_nettype none

package beam_stream_pkg;

    // one channel's eight complex samples which also make up the output beam
    typedef beam_fmt_pkg::cplx_sample_t [beam_fmt_pkg::num_lanes-1:0] lane_vec_t;

    // one complex weight per antenna channel
    typedef beam_fmt_pkg::cplx_weight_t [beam_fmt_pkg::num_channels-1:0] weight_set_t;

    // all channels of one beat as carried by both the input and weighted streams
    typedef struct packed {
        lane_vec_t [beam_fmt_pkg::num_channels-1:0] samples;
        logic                                       last;
    } channel_beat_t;

    // the combined beam after channel summation
    typedef struct packed {
        lane_vec_t samples;
        logic      last;
    } beam_beat_t;

endpackage

`default_nettype wire

// ==== hw/pipe_stage.sv ====
// pipe stage holding one item of any payload type behind a valid/ready handshake
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire logic     clock,
    input  wire logic     resetn,

    // upstream side
    input  wire logic     up_valid,
    input  wire payload_t up_data,
    output logic          up_ready,

    // downstream side
    input  wire logic     down_ready,
    output logic          down_valid,
    output payload_t      down_data
);

    // the slot can take a new item when it is empty or its item leaves this cycle
    assign up_ready = !down_valid || down_ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            down_valid <= 1'b0;
        end else if (up_ready) begin
            // an item that leaves without a replacement empties the slot
            down_valid <= up_valid;
        end
    end

    // the payload only moves on an accepted transfer
    always_ff @(posedge clock) begin
        if (up_ready && up_valid) begin
            down_data <= up_data;
        end
    end

    // a stalled item must hold still until the downstream side takes it
    stall_hold_check: assert property (
        @(posedge clock) disable iff (!resetn)
        (down_valid && !down_ready) |=> (down_valid && $stable(down_data))
    ) else $error("pipe_stage payload changed while stalled");

    // the slot comes out of reset empty
    reset_empty_check: assert property (
        @(posedge clock) !resetn |=> !down_valid
    ) else $error("pipe_stage valid set after reset");

endmodule

`default_nettype wire

// ==== weighting/sample_weighter.sv ====
// complex sample weighter, multiplies one sample by a Q0.7 weight with rounding and saturation
`timescale 1ns/1ps
`default_nettype none

module sample_weighter (
    input  wire beam_fmt_pkg::cplx_sample_t sample,
    input  wire beam_fmt_pkg::cplx_weight_t weight,
    output beam_fmt_pkg::cplx_sample_t      result
);

    // full precision partial products, each one signed sample times signed weight
    logic signed [beam_fmt_pkg::product_w-1:0]      prod_rr;
    logic signed [beam_fmt_pkg::product_w-1:0]      prod_ii;
    logic signed [beam_fmt_pkg::product_w-1:0]      prod_ri;
    logic signed [beam_fmt_pkg::product_w-1:0]      prod_ir;
    logic signed [beam_fmt_pkg::weighted_acc_w-1:0] acc_re;
    logic signed [beam_fmt_pkg::weighted_acc_w-1:0] acc_im;

    // drops the weight's fractional bits half up, then clamps to the sample range
    function automatic beam_fmt_pkg::sample_t round_sat(
        input logic signed [beam_fmt_pkg::weighted_acc_w-1:0] acc
    );
        logic signed [beam_fmt_pkg::weighted_acc_w-1:0]         biased;
        logic signed [beam_fmt_pkg::weighted_acc_w-1:0]         shifted;
        logic [beam_fmt_pkg::weighted_acc_w-beam_fmt_pkg::sample_w:0] head;
        beam_fmt_pkg::sample_t                                  value;
        biased  = acc + beam_fmt_pkg::weighted_acc_w'(beam_fmt_pkg::weight_round);
        shifted = biased >>> beam_fmt_pkg::weight_frac_bits;
        // the value fits when every bit from the sample sign upwards agrees
        head = shifted[beam_fmt_pkg::weighted_acc_w-1:beam_fmt_pkg::sample_w-1];
        if ((&head) || !(|head)) begin
            value = shifted[beam_fmt_pkg::sample_w-1:0];
        end else if (shifted[beam_fmt_pkg::weighted_acc_w-1]) begin
            value = beam_fmt_pkg::sample_min;
        end else begin
            value = beam_fmt_pkg::sample_max;
        end
        return value;
    endfunction

    assign prod_rr = $signed(weight.re) * $signed(sample.re);
    assign prod_ii = $signed(weight.im) * $signed(sample.im);
    assign prod_ri = $signed(weight.re) * $signed(sample.im);
    assign prod_ir = $signed(weight.im) * $signed(sample.re);

    // (wr + j wi)(sr + j si), the extra accumulator bit keeps the sum exact
    assign acc_re = prod_rr - prod_ii;
    assign acc_im = prod_ri + prod_ir;

    assign result.re = round_sat(acc_re);
    assign result.im = round_sat(acc_im);

    // -128 would be a weight of exactly minus one, outside the below-one format
    always_comb begin
        weight_range_check: assert final ($isunknown(weight) ||
            (weight.re != beam_fmt_pkg::weight_min && weight.im != beam_fmt_pkg::weight_min))
        else $error("weight uses the most negative code");
    end

endmodule

`default_nettype wire

// ==== weighting/weighting_stage.sv ====
// weighting stage, applies each channel's complex weight to every lane of a beat
`timescale 1ns/1ps
`default_nettype none

module weighting_stage (
    input  wire beam_stream_pkg::channel_beat_t beat,
    input  wire beam_stream_pkg::weight_set_t   weights,
    output wire beam_stream_pkg::channel_beat_t weighted
);

    // one weighter per channel and lane, all of a channel's lanes share its weight
    for (genvar ch = 0; ch < beam_fmt_pkg::num_channels; ch++) begin : g_channel
        for (genvar ln = 0; ln < beam_fmt_pkg::num_lanes; ln++) begin : g_lane
            sample_weighter u_weighter (
                .sample (beat.samples[ch][ln]),
                .weight (weights[ch]),
                .result (weighted.samples[ch][ln])
            );
        end
    end

    // the last flag belongs to the beat and is untouched by the arithmetic
    assign weighted.last = beat.last;

endmodule

`default_nettype wire

// ==== hw/channel_combiner.sv ====
// channel combiner, sums the weighted channels per lane and scales by a quarter with rounding
`timescale 1ns/1ps
`default_nettype none

module channel_combiner (
    input  wire beam_stream_pkg::channel_beat_t weighted,
    output beam_stream_pkg::beam_beat_t         beam
);

    // sum of one component across all channels, then divide by four half up
    function automatic beam_fmt_pkg::sample_t combine(
        input beam_fmt_pkg::sample_t parts [beam_fmt_pkg::num_channels]
    );
        logic signed [beam_fmt_pkg::beam_sum_w-1:0] sum;
        logic signed [beam_fmt_pkg::beam_sum_w-1:0] shifted;
        sum = '0;
        for (int ch = 0; ch < beam_fmt_pkg::num_channels; ch++) begin
            // the size cast sign-extends each 16-bit part into the 18-bit sum
            sum = sum + beam_fmt_pkg::beam_sum_w'(parts[ch]);
        end
        // four full-scale parts plus the bias still fit, so no clamp is needed
        sum     = sum + beam_fmt_pkg::beam_sum_w'(beam_fmt_pkg::combine_round);
        shifted = sum >>> beam_fmt_pkg::combine_shift;
        return shifted[beam_fmt_pkg::sample_w-1:0];
    endfunction

    always_comb begin
        beam_fmt_pkg::sample_t re_parts [beam_fmt_pkg::num_channels];
        beam_fmt_pkg::sample_t im_parts [beam_fmt_pkg::num_channels];
        for (int ln = 0; ln < beam_fmt_pkg::num_lanes; ln++) begin
            // gather lane ln of every channel
            for (int ch = 0; ch < beam_fmt_pkg::num_channels; ch++) begin
                re_parts[ch] = weighted.samples[ch][ln].re;
                im_parts[ch] = weighted.samples[ch][ln].im;
            end
            beam.samples[ln].re = combine(re_parts);
            beam.samples[ln].im = combine(im_parts);
        end
        beam.last = weighted.last;
    end

endmodule

`default_nettype wire

// ==== hw/beamformer_top.sv ====
// four-channel complex beamformer top, weighting and combining split over two pipe stages
`timescale 1ns/1ps
`default_nettype none

module beamformer_top (
    input  wire logic                          clock,
    input  wire logic                          resetn,

    // input stream, one beat holds every channel's lanes
    input  wire logic                          in_valid,
    input  wire beam_stream_pkg::channel_beat_t in_beat,
    output logic                               in_ready,

    // per-channel weights, taken on the cycle a beat is accepted
    input  wire beam_stream_pkg::weight_set_t   weights,

    // combined beam output stream
    input  wire logic                          out_ready,
    output logic                               out_valid,
    output beam_stream_pkg::beam_beat_t        out_beat
);

    // weighted beat before and after the first register
    wire beam_stream_pkg::channel_beat_t weighted_beat;
    wire beam_stream_pkg::channel_beat_t weighted_q;
    wire logic                           weighted_valid;

    // combined beam before the output register, and that register's ready
    wire beam_stream_pkg::beam_beat_t    beam_beat;
    wire logic                           beam_ready;

    // the weights are applied while the beat waits at the input,
    // so a beat always leaves with the weights present at its acceptance
    weighting_stage u_weighting (
        .beat     (in_beat),
        .weights  (weights),
        .weighted (weighted_beat)
    );

    pipe_stage #(
        .payload_t (beam_stream_pkg::channel_beat_t)
    ) weight_reg (
        .clock      (clock),
        .resetn     (resetn),
        .up_valid   (in_valid),
        .up_data    (weighted_beat),
        .up_ready   (in_ready),
        .down_ready (beam_ready),
        .down_valid (weighted_valid),
        .down_data  (weighted_q)
    );

    channel_combiner u_combiner (
        .weighted (weighted_q),
        .beam     (beam_beat)
    );

    // back-pressure from out_ready ripples to in_ready through both stages
    pipe_stage #(
        .payload_t (beam_stream_pkg::beam_beat_t)
    ) beam_reg (
        .clock      (clock),
        .resetn     (resetn),
        .up_valid   (weighted_valid),
        .up_data    (beam_beat),
        .up_ready   (beam_ready),
        .down_ready (out_ready),
        .down_valid (out_valid),
        .down_data  (out_beat)
    );

endmodule

`default_nettype wire

// ==== bench/beamformer_tb.sv ====
// beamformer testbench with a reference model, directed tests and a cycle timeout
`timescale 1ns/1ps
`default_nettype none

module beamformer_tb;

    // cycle budget of each test with room for gaps and stalls in the random one
    localparam int reset_cycles        = 10;
    localparam int single_cycles       = 10;
    localparam int rounding_cycles     = 20;
    localparam int backpressure_cycles = 30;
    localparam int random_beats        = 200;
    localparam int random_cycles       = 4 * random_beats;
    localparam int cycle_limit = 2 * (reset_cycles + single_cycles + rounding_cycles
        + backpressure_cycles + random_cycles) + 100;

    // two beats in flight leave the pipeline well within this many cycles
    localparam int drain_cycles = 10;

    logic                           clock;
    logic                           resetn;
    logic                           in_valid;
    beam_stream_pkg::channel_beat_t in_beat;
    logic                           in_ready;
    beam_stream_pkg::weight_set_t   weights;
    logic                           out_ready;
    logic                           out_valid;
    beam_stream_pkg::beam_beat_t    out_beat;

    // beams that the model expects with the oldest at the front
    beam_stream_pkg::beam_beat_t expected [$];

    int          value_errors;
    int          stream_errors;
    int          cycle_count;
    logic [31:0] lcg_state;

    beamformer_top DUT (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .weights   (weights),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int clamp_to_sample(input int value);
        if (value > 32767) begin
            return 32767;
        end
        if (value < -32768) begin
            return -32768;
        end
        return value;
    endfunction

    // weight every sample, round half up by 7 bits, saturate, then average the channels
    function automatic beam_stream_pkg::beam_beat_t expected_beam(
        input beam_stream_pkg::channel_beat_t beat,
        input beam_stream_pkg::weight_set_t   w
    );
        beam_stream_pkg::beam_beat_t result;
        int wr;
        int wi;
        int sr;
        int si;
        int sum_re;
        int sum_im;
        for (int ln = 0; ln < beam_fmt_pkg::num_lanes; ln++) begin
            sum_re = 0;
            sum_im = 0;
            for (int ch = 0; ch < beam_fmt_pkg::num_channels; ch++) begin
                wr = int'($signed(w[ch].re));
                wi = int'($signed(w[ch].im));
                sr = int'($signed(beat.samples[ch][ln].re));
                si = int'($signed(beat.samples[ch][ln].im));
                sum_re += clamp_to_sample((wr * sr - wi * si + 64) >>> 7);
                sum_im += clamp_to_sample((wr * si + wi * sr + 64) >>> 7);
            end
            result.samples[ln].re = 16'((sum_re + 2) >>> 2);
            result.samples[ln].im = 16'((sum_im + 2) >>> 2);
        end
        result.last = beat.last;
        return result;
    endfunction

    function automatic beam_stream_pkg::channel_beat_t random_beat(input logic last);
        beam_stream_pkg::channel_beat_t beat;
        logic [31:0] r;
        for (int ch = 0; ch < beam_fmt_pkg::num_channels; ch++) begin
            for (int ln = 0; ln < beam_fmt_pkg::num_lanes; ln++) begin
                r = next_random();
                beat.samples[ch][ln].re = r[31:16];
                r = next_random();
                beat.samples[ch][ln].im = r[31:16];
            end
        end
        beat.last = last;
        return beat;
    endfunction

    // -128 is outside the weight format, so it is pulled in by one code
    function automatic beam_fmt_pkg::weight_t random_weight_part();
        logic [31:0]           r;
        beam_fmt_pkg::weight_t part;
        r    = next_random();
        part = r[31:24];
        if (part == 8'sh80) begin
            part = 8'sh81;
        end
        return part;
    endfunction

    function automatic beam_stream_pkg::weight_set_t random_weights();
        beam_stream_pkg::weight_set_t w;
        for (int ch = 0; ch < beam_fmt_pkg::num_channels; ch++) begin
            w[ch].re = random_weight_part();
            w[ch].im = random_weight_part();
        end
        return w;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_beam(input string name, input beam_stream_pkg::beam_beat_t got,
                              input beam_stream_pkg::beam_beat_t exp);
        for (int ln = 0; ln < beam_fmt_pkg::num_lanes; ln++) begin
            if (got.samples[ln].re !== exp.samples[ln].re) begin
                $display("CHECK FAILED %s.samples[%0d].re: got %h, expected %h",
                         name, ln, got.samples[ln].re, exp.samples[ln].re);
                value_errors++;
            end
            if (got.samples[ln].im !== exp.samples[ln].im) begin
                $display("CHECK FAILED %s.samples[%0d].im: got %h, expected %h",
                         name, ln, got.samples[ln].im, exp.samples[ln].im);
                value_errors++;
            end
        end
        check_bit({name, ".last"}, got.last, exp.last);
    endtask

    // entered and left 1 ns after a rising edge and holds the beat until it is taken
    task automatic send_beat(input beam_stream_pkg::channel_beat_t beat,
                             input beam_stream_pkg::weight_set_t w);
        logic taken;
        in_valid = 1'b1;
        in_beat  = beat;
        weights  = w;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clock);
            taken = in_ready;
            @(posedge clock);
            #1;
        end
        in_valid = 1'b0;
    endtask

    // beats still queued after the bound are left for the closing count
    task automatic wait_drained();
        int waited;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
        end while (expected.size() != 0 && waited < drain_cycles);
        #1;
    endtask

    // the model itself is held against values worked out by hand
    task automatic confirm_model(input beam_stream_pkg::channel_beat_t beat,
                                 input beam_stream_pkg::weight_set_t w,
                                 input beam_stream_pkg::beam_beat_t hand);
        check_beam("model", expected_beam(beat, w), hand);
    endtask

    // inputs are stable at the falling edge, so a transfer seen here happens at the next rise
    always @(negedge clock) begin
        if (resetn && in_valid && in_ready) begin
            expected.push_back(expected_beam(in_beat, weights));
        end
        if (resetn && out_valid && out_ready) begin
            if (expected.size() == 0) begin
                $display("an output beat arrived while no beat was expected");
                stream_errors++;
            end else begin
                check_beam("out_beat", out_beat, expected.pop_front());
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d value mismatches, %0d stream errors",
                     value_errors, stream_errors);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic reset_behavior();
        $display("test: reset");
        repeat (2) begin
            @(posedge clock);
            #1;
            check_bit("out_valid", out_valid, 1'b0);
        end
        resetn = 1'b1;
        // the sink is still not ready but the input side must be
        repeat (2) begin
            @(negedge clock);
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("in_ready", in_ready, 1'b1);
        end
        @(posedge clock);
        #1;
        out_ready = 1'b1;
    endtask

    task automatic single_beat();
        beam_stream_pkg::channel_beat_t beat;
        beam_stream_pkg::weight_set_t   w;
        $display("test: single beat");
        for (int ch = 0; ch < beam_fmt_pkg::num_channels; ch++) begin
            for (int ln = 0; ln < beam_fmt_pkg::num_lanes; ln++) begin
                beat.samples[ch][ln].re = 16'(ln * 1000 - 3500 + ch * 111);
                beat.samples[ch][ln].im = 16'(2000 - ln * 777 - ch * 50);
            end
        end
        beat.last = 1'b1;
        w[0].re = 8'sd64;
        w[0].im = 8'sd0;
        w[1].re = -8'sd32;
        w[1].im = 8'sd16;
        w[2].re = 8'sd100;
        w[2].im = -8'sd50;
        w[3].re = -8'sd127;
        w[3].im = 8'sd127;
        send_beat(beat, w);
        // one cycle in weight_reg, then beam_reg presents it for the second edge
        @(negedge clock);
        check_bit("out_valid", out_valid, 1'b0);
        @(negedge clock);
        check_bit("out_valid", out_valid, 1'b1);
        wait_drained();
    endtask

    task automatic rounding_and_saturation();
        beam_stream_pkg::channel_beat_t beat;
        beam_stream_pkg::weight_set_t   w;
        beam_stream_pkg::beam_beat_t    hand;
        $display("test: rounding and saturation");
        // a weight of 1/128 turns a sample of 64 into exactly one half
        beat = '0;
        for (int ch = 0; ch < beam_fmt_pkg::num_channels; ch++) begin
            w[ch].re = 8'sd1;
            w[ch].im = 8'sd0;
            beat.samples[ch][0].re = 16'sd64;
            beat.samples[ch][0].im = -16'sd64;
            beat.samples[ch][1].re = 16'sd192;
            beat.samples[ch][1].im = -16'sd192;
            beat.samples[ch][2].re = 16'sd320;
            beat.samples[ch][2].im = -16'sd320;
            // channel sums of -2, 10 and -10 sit half way between quarters
            beat.samples[ch][4].re = (ch == 3) ? -16'sd640 : 16'sd128;
            beat.samples[ch][4].im = (ch == 3) ? 16'sd128 : 16'sd384;
            beat.samples[ch][5].re = (ch == 3) ? -16'sd128 : -16'sd384;
        end
        hand = '0;
        hand.samples[0].re = 16'sd1;
        hand.samples[1].re = 16'sd2;
        hand.samples[1].im = -16'sd1;
        hand.samples[2].re = 16'sd3;
        hand.samples[2].im = -16'sd2;
        hand.samples[4].im = 16'sd3;
        hand.samples[5].re = -16'sd2;
        confirm_model(beat, w, hand);
        send_beat(beat, w);
        // full-scale samples against the largest weights drive the products past the range
        beat = '0;
        for (int ch = 0; ch < beam_fmt_pkg::num_channels; ch++) begin
            w[ch].re = 8'sd127;
            w[ch].im = -8'sd127;
            beat.samples[ch][0].re = 16'sh7fff;
            beat.samples[ch][0].im = 16'sh7fff;
            beat.samples[ch][1].re = 16'sh8000;
            beat.samples[ch][1].im = 16'sh8000;
            beat.samples[ch][2].re = 16'sh7fff;
            beat.samples[ch][2].im = 16'sh8000;
        end
        beat.last = 1'b1;
        hand = '0;
        hand.samples[0].re = 16'sh7fff;
        hand.samples[1].re = 16'sh8000;
        hand.samples[2].re = -16'sd1;
        hand.samples[2].im = 16'sh8000;
        hand.last = 1'b1;
        confirm_model(beat, w, hand);
        send_beat(beat, w);
        wait_drained();
    endtask

    task automatic back_pressure();
        beam_stream_pkg::channel_beat_t beats [5];
        beam_stream_pkg::weight_set_t   w;
        $display("test: back-pressure");
        w = random_weights();
        for (int k = 0; k < 5; k++) begin
            beats[k] = random_beat(k % 2 == 1);
        end
        out_ready = 1'b0;
        send_beat(beats[0], w);
        send_beat(beats[1], w);
        // both slots now hold a beat, so the third one has to wait
        in_valid = 1'b1;
        in_beat  = beats[2];
        weights  = w;
        repeat (3) begin
            @(negedge clock);
            check_bit("in_ready", in_ready, 1'b0);
            check_bit("out_valid", out_valid, 1'b1);
        end
        @(posedge clock);
        #1;
        out_ready = 1'b1;
        for (int k = 2; k < 5; k++) begin
            send_beat(beats[k], w);
        end
        wait_drained();
    endtask

    task automatic random_stream();
        int          sent;
        logic        taken;
        logic [31:0] r;
        $display("test: random stream");
        sent = 0;
        while (sent < random_beats) begin
            r = next_random();
            // the sink is ready three cycles out of four
            out_ready = (r[31:30] != 2'b00);
            // an idle source starts a new beat with fresh weights three cycles out of four
            if (!in_valid && r[29:28] != 2'b00) begin
                in_beat  = random_beat(r[27]);
                weights  = random_weights();
                in_valid = 1'b1;
            end
            @(negedge clock);
            taken = in_valid && in_ready;
            @(posedge clock);
            #1;
            if (taken) begin
                in_valid = 1'b0;
                sent++;
            end
        end
        out_ready = 1'b1;
        wait_drained();
    endtask

    initial begin
        clock         = 1'b0;
        resetn        = 1'b0;
        in_valid      = 1'b0;
        in_beat       = '0;
        weights       = '0;
        out_ready     = 1'b0;
        value_errors  = 0;
        stream_errors = 0;
        cycle_count   = 0;
        lcg_state     = 32'd43;
        reset_behavior();
        single_beat();
        rounding_and_saturation();
        back_pressure();
        random_stream();
        if (expected.size() != 0) begin
            $display("%0d expected beats never came out", expected.size());
            stream_errors++;
        end
        $display("errors: %0d value mismatches, %0d stream errors",
                 value_errors, stream_errors);
        if (value_errors + stream_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/beam_fmt_pkg.sv
common/beam_stream_pkg.sv
hw/pipe_stage.sv
weighting/sample_weighter.sv
weighting/weighting_stage.sv
hw/channel_combiner.sv
hw/beamformer_top.sv
bench/beamformer_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = beamformer_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

# the run fails unless the pass message shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { found = 1 } END { exit !found }'

clean:
	rm -rf $(BUILD_DIR)
